// File: build.f
source/fe_fetch_pkg.sv
source/fe_cmd_pkg.sv
source/fe_controller.sv
source/fe_pc_gen.sv
source/fe_fetch_wb.sv
source/fe_top.sv
sim/fe_tb_clk.sv
sim/fe_tb_chk.sv
sim/fe_tb.sv

// File: run_sim.sh
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module fe_tb -f build.f -o fe_sim \
  || { echo "verilator build failed"; exit 1; }
./obj_dir/fe_sim +verilator+error+limit+100 > sim.log 2>&1 || echo "simulator exited with an error"
cat sim.log
grep -q "STATUS: FAIL" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "STATUS: PASS" sim.log || { echo "no final status in sim.log"; exit 1; }
exit 0

// File: sim/fe_tb.sv
// Front end testbench
`timescale 1ns/1ps
`default_nettype none

module fe_tb;

  import fe_cmd_pkg::*;
  import fe_fetch_pkg::*;

  localparam logic [31:0] SEED           = 32'hca93b930;
  localparam instr_t      MEM_PATTERN    = 32'h5a3c_96e1;
  localparam int          TIMEOUT_CYCLES = 4000;  // six tests of about 400 cycles plus margin

  logic       clk;
  logic       reset;
  fe_cmd_s    cmd          = '0;
  logic       cmd_v        = 1'b0;
  logic       cmd_yumi;
  attaboy_s   attaboy;
  logic       attaboy_v;
  logic       attaboy_yumi = 1'b0;
  fetch_pkt_s fetch;
  logic       fetch_v;
  logic       fetch_ready  = 1'b0;
  wb_req_s    wb_req;
  wb_rsp_s    wb_rsp       = '0;

  int     ready_mode     = 0;
  int     ack_wait       = 0;
  int     err_count      = 0;
  int     pkt_count      = 0;
  int     cycle_count    = 0;
  int     tests_run      = 0;
  int     tests_failed   = 0;
  int     test_err_start = 0;
  logic   started        = 1'b0;  // a state reset has been consumed
  logic   halted         = 1'b0;  // a wait is in force
  logic   prev_cyc       = 1'b0;
  vaddr_t exp_pc         = '0;

  fe_tb_clk clock_gen (.clk_o(clk), .reset_o(reset));

  fe_top UUT
    (.clk_i(clk), .reset_i(reset)
    ,.cmd_i(cmd), .cmd_v_i(cmd_v), .cmd_yumi_o(cmd_yumi)
    ,.attaboy_o(attaboy), .attaboy_v_o(attaboy_v), .attaboy_yumi_i(attaboy_yumi)
    ,.fetch_o(fetch), .fetch_v_o(fetch_v), .fetch_ready_i(fetch_ready)
    ,.wb_o(wb_req), .wb_i(wb_rsp)
    );

  bind fe_top fe_tb_chk chk
    (.clk_i(clk_i), .reset_i(reset_i), .flush_i(poison)
    ,.fetch_o(fetch_o), .fetch_v_o(fetch_v_o), .fetch_ready_i(fetch_ready_i)
    ,.wb_o(wb_o), .wb_i(wb_i)
    );

  // ****************************************
  // memory model and back end ready
  // ****************************************

  always @(posedge clk)
  begin
    if (reset)
    begin
      wb_rsp   <= '0;
      ack_wait <= $urandom % 4;
    end
    else if (wb_rsp.ack)
    begin
      wb_rsp.ack <= 1'b0;  // the master drops cyc on this same edge
      ack_wait   <= $urandom % 4;  // wait states for the next read
    end
    else if (wb_req.cyc && wb_req.stb)
    begin
      if (ack_wait == 0)
      begin
        wb_rsp <= '{dat: wb_req.adr ^ MEM_PATTERN, ack: 1'b1};
      end
      else
      begin
        ack_wait <= ack_wait - 1;
      end
    end
  end

  always @(posedge clk)
  begin
    case (ready_mode)
      0:       fetch_ready <= 1'b1;
      1:       fetch_ready <= ($urandom % 4) != 0;
      default: fetch_ready <= ($urandom % 2) != 0;
    endcase
  end

  // ****************************************
  // scoreboard and protocol checks
  // ****************************************

  task automatic report_error(input string msg);
    $display("error at %0d ns: %s", $time, msg);
    err_count++;
  endtask

  function automatic int total_errors();
    return err_count + UUT.chk.fail_count;
  endfunction

  always @(posedge clk)
  begin
    if (reset)
    begin
      assert (!wb_req.cyc && !fetch_v) else report_error("bus or fetch active in reset");
    end
    else
    begin
      if (cmd_v && cmd.opcode == e_op_attaboy)
      begin
        assert (attaboy_v && attaboy.pc == cmd.npc && attaboy.taken == cmd.taken)
          else report_error($sformatf("attaboy %h/%b, expected %h/%b",
                                      attaboy.pc, attaboy.taken, cmd.npc, cmd.taken));
        assert (cmd_yumi == attaboy_yumi) else report_error("attaboy yumi mismatch");
      end
      else
      begin
        assert (!attaboy_v) else report_error("attaboy valid without an attaboy command");
        assert (cmd_yumi == cmd_v) else report_error("command not consumed at once");
      end
      if (!started)
      begin
        assert (!wb_req.cyc) else report_error("bus cycle before the first state reset");
      end
      if (!started || halted)
      begin
        assert (!fetch_v) else report_error("packet while fetch is stopped");
      end
      if (halted)
      begin
        assert (!(wb_req.cyc && !prev_cyc)) else report_error("new bus cycle during wait");
      end
      if (fetch_v && fetch_ready)
      begin
        assert (fetch.pc == exp_pc)
          else report_error($sformatf("pc %h, expected %h", fetch.pc, exp_pc));
        assert (fetch.instr == (exp_pc ^ MEM_PATTERN))
          else report_error($sformatf("instr %h, expected %h",
                                      fetch.instr, exp_pc ^ MEM_PATTERN));
        exp_pc    = exp_pc + 32'd4;
        pkt_count <= pkt_count + 1;
      end
      if (cmd_v && cmd_yumi)
      begin
        if (cmd.opcode == e_op_state_reset || (started && cmd.opcode == e_op_pc_redirect))
        begin
          started = 1'b1;
          halted  = 1'b0;
          exp_pc  = cmd.npc;
        end
        else if (started && cmd.opcode == e_op_wait)
        begin
          halted = 1'b1;
        end
      end
    end
    prev_cyc = wb_req.cyc;
  end

  // ****************************************
  // stimulus
  // ****************************************

  task automatic send_cmd(input fe_opcode_e op, input vaddr_t npc, input logic taken);
    cmd   <= '{opcode: op, npc: npc, taken: taken};
    cmd_v <= 1'b1;
    @(posedge clk);
    while (!cmd_yumi)
    begin
      @(posedge clk);
    end
    cmd_v <= 1'b0;
  endtask

  task automatic send_attaboy(input vaddr_t pc, input logic taken, input int delay);
    cmd   <= '{opcode: e_op_attaboy, npc: pc, taken: taken};
    cmd_v <= 1'b1;
    repeat (delay) @(posedge clk);  // predictor busy for a while
    attaboy_yumi <= 1'b1;
    @(posedge clk);
    while (!cmd_yumi)
    begin
      @(posedge clk);
    end
    cmd_v        <= 1'b0;
    attaboy_yumi <= 1'b0;
  endtask

  task automatic wait_packets(input int n);
    int target;
    target = pkt_count + n;
    while (pkt_count < target)
    begin
      @(posedge clk);
    end
  endtask

  task automatic start_test();
    test_err_start = total_errors();
  endtask

  task automatic end_test(input string name);
    int errs;
    errs = total_errors() - test_err_start;
    tests_run++;
    if (errs == 0)
    begin
      $display("test %s: passed", name);
    end
    else
    begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, errs);
    end
  endtask

  initial
  begin
    while (cycle_count < TIMEOUT_CYCLES)
    begin
      @(posedge clk);
      cycle_count++;
    end
    $display("timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("STATUS: FAIL");
    $finish;
  end

  initial
  begin
    int i;
    void'($urandom(SEED));
    while (reset !== 1'b0)
    begin
      @(posedge clk);
    end

    start_test();
    send_cmd(e_op_wait, 32'h0000_0040, 1'b0);  // swallowed before the first state reset
    send_cmd(e_op_pc_redirect, 32'h0000_4000, 1'b0);
    send_attaboy(32'h0000_0100, 1'b1, 2);
    repeat (20) @(posedge clk);
    send_cmd(e_op_state_reset, 32'h0000_1000, 1'b0);
    wait_packets(40);
    end_test("reset and start");

    start_test();
    ready_mode <= 2;
    wait_packets(60);
    ready_mode <= 1;
    end_test("instruction data");

    start_test();
    for (i = 0; i < 3; i++)
    begin
      send_cmd(e_op_pc_redirect, 32'h0000_8000 + i * 32'h100, 1'b0);
      wait_packets(12);
    end
    send_cmd(e_op_pc_redirect, 32'h0001_0000, 1'b0);
    send_cmd(e_op_pc_redirect, 32'h0001_2000, 1'b0);
    wait_packets(12);
    end_test("pc redirect");

    start_test();
    send_cmd(e_op_wait, 32'h0, 1'b0);
    repeat (40) @(posedge clk);
    send_cmd(e_op_pc_redirect, 32'h0002_0000, 1'b0);
    wait_packets(12);
    send_cmd(e_op_wait, 32'h0, 1'b0);
    repeat (20) @(posedge clk);
    send_cmd(e_op_state_reset, 32'h0003_0000, 1'b0);
    wait_packets(12);
    end_test("wait");

    start_test();
    for (i = 0; i < 4; i++)
    begin
      send_attaboy(vaddr_t'($urandom) & 32'hffff_fffc, ($urandom % 2) == 1, 1 + i);
      wait_packets(5);
    end
    end_test("attaboy");

    start_test();
    ready_mode <= 2;
    for (i = 0; i < 5; i++)
    begin
      wait_packets(6);
      send_cmd(e_op_pc_redirect, vaddr_t'($urandom) & 32'h000f_fffc, 1'b0);
    end
    wait_packets(6);
    ready_mode <= 0;
    repeat (10) @(posedge clk);
    end_test("handshake rules");

    $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, total_errors());
    if (tests_failed == 0 && total_errors() == 0)
    begin
      $display("STATUS: PASS");
    end
    else
    begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sim/fe_tb_chk.sv
// Front end handshake checks
`timescale 1ns/1ps
`default_nettype none

module fe_tb_chk
  (
    input logic                       clk_i
  , input logic                       reset_i
  , input logic                       flush_i
  , input fe_fetch_pkg::fetch_pkt_s   fetch_o
  , input logic                       fetch_v_o
  , input logic                       fetch_ready_i
  , input fe_fetch_pkg::wb_req_s      wb_o
  , input fe_fetch_pkg::wb_rsp_s      wb_i
  );

  int fail_count = 0;

  // a flush may empty a stalled output slot
  a_fetch_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    (fetch_v_o && !fetch_ready_i && !flush_i) |=> (fetch_v_o && $stable(fetch_o)))
    else
    begin
      fail_count++;
      $error("fetch packet changed while the back end stalled");
    end

  a_stb_cyc: assert property (@(posedge clk_i) disable iff (reset_i)
    wb_o.stb == wb_o.cyc)
    else
    begin
      fail_count++;
      $error("stb differs from cyc");
    end

  a_adr_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    (wb_o.cyc && !wb_i.ack) |=> (wb_o.cyc && $stable(wb_o.adr)))
    else
    begin
      fail_count++;
      $error("bus cycle ended or address moved before ack");
    end

  a_cyc_drop: assert property (@(posedge clk_i) disable iff (reset_i)
    (wb_o.cyc && wb_i.ack) |=> !wb_o.cyc)
    else
    begin
      fail_count++;
      $error("cyc still high in the cycle after ack");
    end

endmodule

`default_nettype wire

// File: sim/fe_tb_clk.sv
// Testbench clock and reset
`timescale 1ns/1ps
`default_nettype none

module fe_tb_clk
  (
    output logic clk_o
  , output logic reset_o
  );

  initial
  begin
    clk_o = 1'b0;
    forever #20 clk_o = ~clk_o;  // 40 ns period
  end

  initial
  begin
    reset_o = 1'b1;
    repeat (16) @(posedge clk_o);
    reset_o <= 1'b0;
  end

endmodule

`default_nettype wire

// File: source/fe_cmd_pkg.sv
// Front end command types
`default_nettype none

package fe_cmd_pkg;

  // ****************************************
  // back end to front end commands
  // ****************************************

  typedef enum logic [1:0] {
    e_op_state_reset,   // first redirect after reset
    e_op_pc_redirect,   // flush and restart at npc
    e_op_wait,          // flush and stop fetching
    e_op_attaboy        // branch prediction was correct
  } fe_opcode_e;

  // npc doubles as the branch pc for an attaboy
  typedef struct packed {
    fe_opcode_e           opcode;
    fe_fetch_pkg::vaddr_t npc;
    logic                 taken;
  } fe_cmd_s;

  // ****************************************
  // predictor notice
  // ****************************************

  typedef struct packed {
    fe_fetch_pkg::vaddr_t pc;
    logic                 taken;  // direction the branch resolved to
  } attaboy_s;

endpackage

`default_nettype wire

// File: source/fe_controller.sv
// Front end command controller
`timescale 1ns/1ps
`default_nettype none

module fe_controller
  (
    input  logic                   clk_i
  , input  logic                   reset_i

  , input  fe_cmd_pkg::fe_cmd_s    cmd_i
  , input  logic                   cmd_v_i
  , output logic                   cmd_yumi_o

  , output fe_cmd_pkg::attaboy_s   attaboy_o
  , output logic                   attaboy_v_o
  , input  logic                   attaboy_yumi_i

  , output logic                   redirect_v_o
  , output fe_fetch_pkg::vaddr_t   redirect_pc_o
  , output logic                   fetch_en_o
  , output logic                   poison_o
  );

  import fe_cmd_pkg::*;

  typedef enum logic [1:0] {e_reset, e_run, e_wait} ctrl_state_e;

  ctrl_state_e state_r;
  ctrl_state_e state_n;

  logic state_reset_v;
  logic pc_redirect_v;
  logic wait_v;
  logic attaboy_v;
  logic nonattaboy_v;

  // ****************************************
  // command decode
  // ****************************************

  assign state_reset_v = cmd_v_i & (cmd_i.opcode == e_op_state_reset);
  assign pc_redirect_v = cmd_v_i & (cmd_i.opcode == e_op_pc_redirect);
  assign wait_v        = cmd_v_i & (cmd_i.opcode == e_op_wait);
  assign attaboy_v     = cmd_v_i & (cmd_i.opcode == e_op_attaboy);
  assign nonattaboy_v  = cmd_v_i & (cmd_i.opcode != e_op_attaboy);

  // attaboys wait for the predictor, everything else goes at once
  assign cmd_yumi_o = nonattaboy_v | (attaboy_v & attaboy_yumi_i);

  assign attaboy_v_o = attaboy_v;
  assign attaboy_o   = '{pc: cmd_i.npc, taken: cmd_i.taken};

  assign redirect_pc_o = cmd_i.npc;

  always_comb
  begin
    state_n      = state_r;
    redirect_v_o = 1'b0;
    poison_o     = 1'b0;
    case (state_r)
      e_reset:
      begin
        redirect_v_o = state_reset_v;  // other commands are swallowed here
        if (state_reset_v)
        begin
          state_n = e_run;
        end
      end
      e_run, e_wait:
      begin
        redirect_v_o = state_reset_v | pc_redirect_v;
        poison_o     = state_reset_v | pc_redirect_v | wait_v;
        if (state_reset_v | pc_redirect_v)
        begin
          state_n = e_run;
        end
        else if (wait_v)
        begin
          state_n = e_wait;
        end
      end
      default:
      begin
        state_n = e_reset;
      end
    endcase
  end

  // no launch in the cycle the pc is being replaced
  assign fetch_en_o = (state_r == e_run) & ~redirect_v_o & ~wait_v;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      state_r <= e_reset;
    end
    else
    begin
      state_r <= state_n;
    end
  end

endmodule

`default_nettype wire

// File: source/fe_fetch_pkg.sv
// Fetch datapath types
`default_nettype none

package fe_fetch_pkg;

  // ****************************************
  // basic widths
  // ****************************************

  typedef logic [31:0] vaddr_t;  // byte address of a fetch
  typedef logic [31:0] instr_t;  // one uncompressed instruction

  // ****************************************
  // packets and bus
  // ****************************************

  // handed to the back end, pc first
  typedef struct packed {
    vaddr_t pc;
    instr_t instr;
  } fetch_pkt_s;

  // Wishbone classic master side, read only
  typedef struct packed {
    logic   cyc;
    logic   stb;
    vaddr_t adr;
  } wb_req_s;

  // Wishbone classic slave side
  typedef struct packed {
    instr_t dat;
    logic   ack;
  } wb_rsp_s;

endpackage

`default_nettype wire

// File: source/fe_fetch_wb.sv
// Wishbone fetch unit
`timescale 1ns/1ps
`default_nettype none

module fe_fetch_wb
  (
    input  logic                       clk_i
  , input  logic                       reset_i

  , input  logic                       fetch_en_i
  , input  logic                       poison_i
  , input  fe_fetch_pkg::vaddr_t       pc_i
  , output logic                       launch_o

  , output fe_fetch_pkg::wb_req_s      wb_o
  , input  fe_fetch_pkg::wb_rsp_s      wb_i

  , output fe_fetch_pkg::fetch_pkt_s   fetch_o
  , output logic                       fetch_v_o
  , input  logic                       fetch_ready_i
  );

  import fe_fetch_pkg::*;

  // ****************************************
  // bus cycle
  // ****************************************

  logic   cyc_r;
  logic   stale_r;  // set once the active read belongs to a flushed stream
  vaddr_t adr_r;

  logic   ack_fire;
  logic   result_v;
  fetch_pkt_s result_pkt;

  logic       hold_v_r;
  fetch_pkt_s hold_pkt_r;
  logic       out_v_r;
  fetch_pkt_s out_pkt_r;
  logic       out_free;

  assign launch_o = fetch_en_i & ~cyc_r & ~hold_v_r;

  assign ack_fire   = cyc_r & wb_i.ack;
  assign result_v   = ack_fire & ~stale_r & ~poison_i;
  assign result_pkt = '{pc: adr_r, instr: wb_i.dat};

  assign wb_o = '{cyc: cyc_r, stb: cyc_r, adr: adr_r};

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      cyc_r   <= 1'b0;
      stale_r <= 1'b0;
    end
    else if (launch_o)
    begin
      cyc_r   <= 1'b1;
      stale_r <= 1'b0;
    end
    else
    begin
      if (ack_fire)
      begin
        cyc_r <= 1'b0;  // classic bus drops cyc right after ack
      end
      if (poison_i & cyc_r)
      begin
        stale_r <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (launch_o)
    begin
      adr_r <= pc_i;
    end
  end

  // ****************************************
  // holding and output slots
  // ****************************************

  assign out_free = ~out_v_r | fetch_ready_i;

  always_ff @(posedge clk_i)
  begin
    if (reset_i | poison_i)
    begin
      hold_v_r <= 1'b0;
      out_v_r  <= 1'b0;
    end
    else if (out_free)
    begin
      out_v_r  <= hold_v_r | result_v;
      hold_v_r <= hold_v_r & result_v;  // refill behind the packet moving out
    end
    else if (result_v)
    begin
      hold_v_r <= 1'b1;
    end
  end

  // payload follows the valid bits above
  always_ff @(posedge clk_i)
  begin
    if (out_free)
    begin
      out_pkt_r <= hold_v_r ? hold_pkt_r : result_pkt;
    end
    if (result_v & (hold_v_r | ~out_free))
    begin
      hold_pkt_r <= result_pkt;
    end
  end

  assign fetch_o   = out_pkt_r;
  assign fetch_v_o = out_v_r;

endmodule

`default_nettype wire

// File: source/fe_pc_gen.sv
// Fetch program counter
`timescale 1ns/1ps
`default_nettype none

module fe_pc_gen
  (
    input  logic                   clk_i
  , input  logic                   reset_i

  , input  logic                   redirect_v_i
  , input  fe_fetch_pkg::vaddr_t   redirect_pc_i
  , input  logic                   launch_i

  , output fe_fetch_pkg::vaddr_t   pc_o
  );

  import fe_fetch_pkg::*;

  vaddr_t pc_r;  // address of the next read to launch

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      pc_r <= '0;
    end
    else if (redirect_v_i)
    begin
      pc_r <= redirect_pc_i;  // redirect wins over a launch
    end
    else if (launch_i)
    begin
      pc_r <= pc_r + vaddr_t'(4);
    end
  end

  assign pc_o = pc_r;

endmodule

`default_nettype wire

// File: source/fe_top.sv
// Instruction fetch front end
`timescale 1ns/1ps
`default_nettype none

module fe_top
  (
    input  logic                       clk_i
  , input  logic                       reset_i

  , input  fe_cmd_pkg::fe_cmd_s        cmd_i
  , input  logic                       cmd_v_i
  , output logic                       cmd_yumi_o

  , output fe_cmd_pkg::attaboy_s       attaboy_o
  , output logic                       attaboy_v_o
  , input  logic                       attaboy_yumi_i

  , output fe_fetch_pkg::fetch_pkt_s   fetch_o
  , output logic                       fetch_v_o
  , input  logic                       fetch_ready_i

  , output fe_fetch_pkg::wb_req_s      wb_o
  , input  fe_fetch_pkg::wb_rsp_s      wb_i
  );

  import fe_fetch_pkg::*;

  logic   redirect_v;
  vaddr_t redirect_pc;
  logic   fetch_en;
  logic   poison;
  logic   launch;
  vaddr_t pc;

  fe_controller controller
    (.clk_i          (clk_i)
    ,.reset_i        (reset_i)
    ,.cmd_i          (cmd_i)
    ,.cmd_v_i        (cmd_v_i)
    ,.cmd_yumi_o     (cmd_yumi_o)
    ,.attaboy_o      (attaboy_o)
    ,.attaboy_v_o    (attaboy_v_o)
    ,.attaboy_yumi_i (attaboy_yumi_i)
    ,.redirect_v_o   (redirect_v)
    ,.redirect_pc_o  (redirect_pc)
    ,.fetch_en_o     (fetch_en)
    ,.poison_o       (poison)
    );

  fe_pc_gen pc_gen
    (.clk_i         (clk_i)
    ,.reset_i       (reset_i)
    ,.redirect_v_i  (redirect_v)
    ,.redirect_pc_i (redirect_pc)
    ,.launch_i      (launch)
    ,.pc_o          (pc)
    );

  fe_fetch_wb fetch_wb
    (.clk_i         (clk_i)
    ,.reset_i       (reset_i)
    ,.fetch_en_i    (fetch_en)
    ,.poison_i      (poison)
    ,.pc_i          (pc)
    ,.launch_o      (launch)
    ,.wb_o          (wb_o)
    ,.wb_i          (wb_i)
    ,.fetch_o       (fetch_o)
    ,.fetch_v_o     (fetch_v_o)
    ,.fetch_ready_i (fetch_ready_i)
    );

endmodule

`default_nettype wire
